//--- Bender.yml
package:
  name: neureka_ctrl

sources:
  - files:
      - verilog/neureka_ctrl_pkg.sv
      - verilog/neureka_cfg_reg.sv
      - verilog/neureka_loop_nest.sv
      - verilog/neureka_index_reg.sv
      - verilog/neureka_ctrl_fsm.sv
      - verilog/neureka_ctrl_top.sv
  - target: test
    files:
      - tb/neureka_ctrl_monitor.sv
      - tb/neureka_ctrl_chk.sv
      - tb/neureka_ctrl_tb.sv

//--- flist.f
verilog/neureka_ctrl_pkg.sv
verilog/neureka_cfg_reg.sv
verilog/neureka_loop_nest.sv
verilog/neureka_index_reg.sv
verilog/neureka_ctrl_fsm.sv
verilog/neureka_ctrl_top.sv
tb/neureka_ctrl_monitor.sv
tb/neureka_ctrl_chk.sv
tb/neureka_ctrl_tb.sv

//--- tb/neureka_ctrl_chk.sv
//////////////////////////////
// FSM protocol assertions
// Bound to the tile sequencing FSM
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module neureka_ctrl_chk (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          clear_i,
  input neureka_ctrl_pkg::ctrl_state_t state_i,
  input logic                          state_change_i
);

  int change_fails = 0;
  int done_fails   = 0;
  int upd_fails    = 0;
  int fail_total;

  assign fail_total = change_fails + done_fails + upd_fails;

  change_tracks_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
      state_change_i == (state_i != $past(state_i)))
    else begin
      $error("state_change_o does not follow the changes of state_o");
      change_fails++;
    end

  done_then_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      state_i == neureka_ctrl_pkg::ST_DONE |=> state_i == neureka_ctrl_pkg::ST_IDLE)
    else begin
      $error("ST_DONE was not followed by ST_IDLE");
      done_fails++;
    end

  // Step in the first cycle, step-done in the second
  updateidx_two_cycles: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
      state_change_i && state_i == neureka_ctrl_pkg::ST_UPDATEIDX |=>
      state_i == neureka_ctrl_pkg::ST_UPDATEIDX ##1 state_i != neureka_ctrl_pkg::ST_UPDATEIDX)
    else begin
      $error("ST_UPDATEIDX did not last exactly two cycles");
      upd_fails++;
    end

endmodule

bind neureka_ctrl_fsm neureka_ctrl_chk u_chk (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .clear_i        (clear_i),
  .state_i        (state_o),
  .state_change_i (state_change_o)
);

`default_nettype wire

//--- tb/neureka_ctrl_monitor.sv
//////////////////////////////
// Controller output monitor
// Counts state entries per job and compares them,
// the final tile index and the clear response
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module neureka_ctrl_monitor (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  neureka_ctrl_pkg::ctrl_state_t state_i,
  input  logic                          state_change_i,
  input  neureka_ctrl_pkg::tile_index_t index_i,
  input  logic [95:0]                   test_name_i,
  input  int                            exp_load_i,
  input  int                            exp_streamin_i,
  input  int                            exp_normquant_i,
  input  int                            exp_streamout_i,
  input  neureka_ctrl_pkg::tile_index_t exp_index_i,
  output int                            err_cnt_o,
  output int                            chk_cnt_o,
  output int                            done_cnt_o
);

  int   n_load, n_streamin, n_normquant, n_streamout;
  int   errs   = 0;
  int   checks = 0;
  int   dones  = 0;
  logic clear_q = 1'b0;
  logic done_q  = 1'b0;

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errs++;
      $display("MISMATCH %s %s: expected %0h, actual %0h", test_name_i, what, exp, act);
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      clear_q = 1'b0;
      done_q  = 1'b0;
    end else begin
      if (clear_q) begin  // One cycle after clear the FSM rests and the index is empty
        compare("state after clear", neureka_ctrl_pkg::ST_IDLE, state_i);
        compare("index after clear", '0, index_i);
      end
      if (done_q && state_i != neureka_ctrl_pkg::ST_IDLE) begin
        errs++;
        $display("ERROR %s: the state after ST_DONE is not ST_IDLE", test_name_i);
      end
      if (state_i == neureka_ctrl_pkg::ST_IDLE) begin
        n_load      = 0;
        n_streamin  = 0;
        n_normquant = 0;
        n_streamout = 0;
      end else if (state_change_i) begin
        case (state_i)
          neureka_ctrl_pkg::ST_LOAD:      n_load++;
          neureka_ctrl_pkg::ST_STREAMIN:  n_streamin++;
          neureka_ctrl_pkg::ST_NORMQUANT: n_normquant++;
          neureka_ctrl_pkg::ST_STREAMOUT: n_streamout++;
          neureka_ctrl_pkg::ST_DONE: begin
            compare("ST_LOAD entries", exp_load_i, n_load);
            compare("ST_STREAMIN entries", exp_streamin_i, n_streamin);
            compare("ST_NORMQUANT entries", exp_normquant_i, n_normquant);
            compare("ST_STREAMOUT entries", exp_streamout_i, n_streamout);
            compare("final index", exp_index_i, index_i);
            dones++;
          end
          default: ;
        endcase
      end
      done_q  = (state_i == neureka_ctrl_pkg::ST_DONE);
      clear_q = clear_i;
    end
  end

  assign err_cnt_o  = errs;
  assign chk_cnt_o  = checks;
  assign done_cnt_o = dones;

endmodule

`default_nettype wire

//--- tb/neureka_ctrl_tb.sv
//////////////////////////////
// Sequencing controller testbench
// Runs a job table against an engine model
// that answers each state after a random delay
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module neureka_ctrl_tb;

  localparam int MAX_JOBS = 8;

  logic                           clk;
  logic                           rst_n;
  logic                           clear;
  logic                           start;
  neureka_ctrl_pkg::filter_mode_t mode;
  neureka_ctrl_pkg::cnt_t         nb_ki, nb_wo, nb_ho, nb_ko;
  logic                           streamin, quant;
  logic                           load_done      = 1'b0;
  logic                           streamin_done  = 1'b0;
  logic                           accum_done     = 1'b0;
  logic                           normquant_done = 1'b0;
  logic                           streamout_done = 1'b0;
  logic                           fifo_empty     = 1'b0;
  neureka_ctrl_pkg::ctrl_state_t  state;
  logic                           state_change;
  neureka_ctrl_pkg::tile_index_t  index;

  //////////////////////////////
  // Job table

  logic [95:0]                   job_name  [MAX_JOBS];
  logic                          job_dw    [MAX_JOBS];
  neureka_ctrl_pkg::cnt_t        job_rng   [MAX_JOBS][4];  // ki, wo, ho, ko
  logic                          job_si    [MAX_JOBS];
  logic                          job_q     [MAX_JOBS];
  int                            job_abort [MAX_JOBS];     // Clear after this many loads
  int                            job_exp   [MAX_JOBS][4];  // load, streamin, normquant, streamout
  neureka_ctrl_pkg::tile_index_t job_idx   [MAX_JOBS];
  int                            num_jobs    = 0;
  int                            cycle_limit = 0;
  int                            cycles      = 0;

  logic [95:0]                   cur_name = '0;
  int                            exp_load, exp_si, exp_nq, exp_so;
  neureka_ctrl_pkg::tile_index_t exp_idx;
  int                            mon_errs, mon_checks, done_cnt;
  logic [31:0]                   seed = 32'h7102;
  logic                          pending = 1'b0;
  logic [2:0]                    wait_cnt = '0;
  neureka_ctrl_pkg::ctrl_state_t pend_state;

  task automatic add_job(input logic [95:0] name, input logic dw, input int ki, wo, ho, ko,
                         input logic si, q, input int abort_at,
                         input int e_load, e_si, e_nq, e_so, input logic [31:0] e_idx);
    int iters;
    iters = dw ? wo * ho * ko : ki * wo * ho * ko;
    job_name[num_jobs]   = name;
    job_dw[num_jobs]     = dw;
    job_rng[num_jobs][0] = neureka_ctrl_pkg::cnt_t'(ki);
    job_rng[num_jobs][1] = neureka_ctrl_pkg::cnt_t'(wo);
    job_rng[num_jobs][2] = neureka_ctrl_pkg::cnt_t'(ho);
    job_rng[num_jobs][3] = neureka_ctrl_pkg::cnt_t'(ko);
    job_si[num_jobs]     = si;
    job_q[num_jobs]      = q;
    job_abort[num_jobs]  = abort_at;
    job_exp[num_jobs][0] = e_load;
    job_exp[num_jobs][1] = e_si;
    job_exp[num_jobs][2] = e_nq;
    job_exp[num_jobs][3] = e_so;
    job_idx[num_jobs]    = e_idx;
    num_jobs++;
    cycle_limit += iters * 64 + 32;  // Eight states per tile, each at most six cycles
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  //////////////////////////////
  // DUT and monitor

  neureka_ctrl_top u_dut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .clear_i          (clear),
    .start_i          (start),
    .mode_i           (mode),
    .nb_ki_i          (nb_ki),
    .nb_wo_i          (nb_wo),
    .nb_ho_i          (nb_ho),
    .nb_ko_i          (nb_ko),
    .streamin_i       (streamin),
    .quant_i          (quant),
    .load_done_i      (load_done),
    .streamin_done_i  (streamin_done),
    .accum_done_i     (accum_done),
    .normquant_done_i (normquant_done),
    .streamout_done_i (streamout_done),
    .fifo_empty_i     (fifo_empty),
    .state_o          (state),
    .state_change_o   (state_change),
    .index_o          (index)
  );

  neureka_ctrl_monitor u_mon (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .clear_i         (clear),
    .state_i         (state),
    .state_change_i  (state_change),
    .index_i         (index),
    .test_name_i     (cur_name),
    .exp_load_i      (exp_load),
    .exp_streamin_i  (exp_si),
    .exp_normquant_i (exp_nq),
    .exp_streamout_i (exp_so),
    .exp_index_i     (exp_idx),
    .err_cnt_o       (mon_errs),
    .chk_cnt_o       (mon_checks),
    .done_cnt_o      (done_cnt)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Engine model, one strobe per state entry
  always @(posedge clk) begin
    load_done      <= 1'b0;
    streamin_done  <= 1'b0;
    accum_done     <= 1'b0;
    normquant_done <= 1'b0;
    streamout_done <= 1'b0;
    fifo_empty     <= 1'b0;
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (state_change) begin
      seed = lcg_next(seed);
      wait_cnt   <= {1'b0, seed[17:16]} + 3'd1;
      pending    <= 1'b1;
      pend_state <= state;
    end else if (pending) begin
      if (wait_cnt == 3'd1) begin
        pending <= 1'b0;
        case (pend_state)
          neureka_ctrl_pkg::ST_LOAD:           load_done      <= 1'b1;
          neureka_ctrl_pkg::ST_STREAMIN:       streamin_done  <= 1'b1;
          neureka_ctrl_pkg::ST_WEIGHTOFFS:     accum_done     <= 1'b1;
          neureka_ctrl_pkg::ST_MATRIXVEC:      accum_done     <= 1'b1;
          neureka_ctrl_pkg::ST_NORMQUANT:      normquant_done <= 1'b1;
          neureka_ctrl_pkg::ST_STREAMOUT:      streamout_done <= 1'b1;
          neureka_ctrl_pkg::ST_STREAMOUT_DONE: fifo_empty     <= 1'b1;
          default: ;
        endcase
      end else begin
        wait_cnt <= wait_cnt - 3'd1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: the jobs did not finish within %0d cycles", cycle_limit);
      $display("Something failed");
      $finish;
    end
  end

  //////////////////////////////
  // Job sequence

  initial begin : main
    int loads_seen;
    int done_before;
    int asrt_fails;
    rst_n    = 1'b0;
    clear    = 1'b0;
    start    = 1'b0;
    mode     = neureka_ctrl_pkg::MODE_DENSE;
    nb_ki    = '0;
    nb_wo    = '0;
    nb_ho    = '0;
    nb_ko    = '0;
    streamin = 1'b0;
    quant    = 1'b0;
    exp_load = 0;
    exp_si   = 0;
    exp_nq   = 0;
    exp_so   = 0;
    exp_idx  = '0;
    //       name           dw    ki wo ho ko si    q     ab ld si nq so index
    add_job("dense_q_si",  1'b0, 2, 2, 1, 2, 1'b1, 1'b1, 0, 8, 4, 4, 4, 32'h01_00_01_01);
    add_job("dense_plain", 1'b0, 3, 1, 2, 1, 1'b0, 1'b0, 0, 6, 0, 0, 2, 32'h00_01_00_02);
    add_job("dw_si",       1'b1, 5, 2, 2, 2, 1'b1, 1'b0, 0, 8, 8, 0, 8, 32'h01_01_01_01);
    add_job("dense_ki1",   1'b0, 1, 3, 1, 1, 1'b1, 1'b1, 0, 3, 3, 3, 3, 32'h00_00_02_00);
    add_job("clear_mid",   1'b0, 4, 2, 2, 2, 1'b1, 1'b1, 3, 0, 0, 0, 0, 32'h00_00_00_00);
    add_job("dw_quant",    1'b1, 1, 1, 3, 1, 1'b0, 1'b1, 0, 3, 0, 3, 3, 32'h00_02_00_00);
    add_job("dense_short", 1'b0, 2, 1, 1, 1, 1'b1, 1'b0, 0, 2, 1, 0, 1, 32'h00_00_00_01);
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    for (int j = 0; j < num_jobs; j++) begin
      done_before = done_cnt;
      @(posedge clk);
      cur_name <= job_name[j];
      mode     <= job_dw[j] ? neureka_ctrl_pkg::MODE_DW : neureka_ctrl_pkg::MODE_DENSE;
      nb_ki    <= job_rng[j][0];
      nb_wo    <= job_rng[j][1];
      nb_ho    <= job_rng[j][2];
      nb_ko    <= job_rng[j][3];
      streamin <= job_si[j];
      quant    <= job_q[j];
      exp_load <= job_exp[j][0];
      exp_si   <= job_exp[j][1];
      exp_nq   <= job_exp[j][2];
      exp_so   <= job_exp[j][3];
      exp_idx  <= job_idx[j];
      start    <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      if (job_abort[j] > 0) begin
        loads_seen = 0;
        while (loads_seen < job_abort[j]) begin
          @(negedge clk);
          if (state_change && state == neureka_ctrl_pkg::ST_LOAD) loads_seen++;
        end
        @(posedge clk);
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        repeat (3) @(posedge clk);
      end else begin
        while (done_cnt == done_before) @(negedge clk);
      end
    end
    repeat (4) @(posedge clk);
    asrt_fails = u_dut.i_ctrl_fsm.u_chk.fail_total;
    $display("Summary: %0d checks, %0d mismatches, %0d assertion failures, %0d jobs done",
             mon_checks, mon_errs, asrt_fails, done_cnt);
    if (mon_errs == 0 && asrt_fails == 0 && mon_checks > 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/neureka_cfg_reg.sv
//////////////////////////////
// Job configuration register
// Holds the settings of a run from start to completion
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module neureka_cfg_reg (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           clear_i,
  input  logic                           capture_i,
  input  logic                           release_i,
  input  neureka_ctrl_pkg::filter_mode_t mode_i,
  input  neureka_ctrl_pkg::cnt_t         nb_ki_i,
  input  neureka_ctrl_pkg::cnt_t         nb_wo_i,
  input  neureka_ctrl_pkg::cnt_t         nb_ho_i,
  input  neureka_ctrl_pkg::cnt_t         nb_ko_i,
  input  logic                           streamin_i,
  input  logic                           quant_i,
  output neureka_ctrl_pkg::filter_mode_t mode_o,
  output neureka_ctrl_pkg::cnt_t         nb_ki_o,
  output neureka_ctrl_pkg::cnt_t         nb_wo_o,
  output neureka_ctrl_pkg::cnt_t         nb_ho_o,
  output neureka_ctrl_pkg::cnt_t         nb_ko_o,
  output logic                           streamin_o,
  output logic                           quant_o,
  output logic                           busy_o
);

  logic busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (clear_i || release_i) begin
      busy_q <= 1'b0;
    end else if (capture_i) begin
      busy_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      mode_o     <= mode_i;
      nb_ki_o    <= nb_ki_i;
      nb_wo_o    <= nb_wo_i;
      nb_ho_o    <= nb_ho_i;
      nb_ko_o    <= nb_ko_i;
      streamin_o <= streamin_i;
      quant_o    <= quant_i;
    end
  end

  assign busy_o = busy_q;

endmodule

`default_nettype wire

//--- verilog/neureka_ctrl_fsm.sv
//////////////////////////////
// Tile sequencing FSM
// Steps each tile from load to stream-out and drives
// the loop nest and the index sampling
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module neureka_ctrl_fsm (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          start_i,
  input  logic                          busy_i,
  input  logic                          load_done_i,
  input  logic                          streamin_done_i,
  input  logic                          accum_done_i,
  input  logic                          normquant_done_i,
  input  logic                          streamout_done_i,
  input  logic                          fifo_empty_i,
  input  logic                          step_done_i,
  input  logic                          inner_only_i,
  input  logic                          last_i,
  input  logic                          streamin_en_i,
  input  logic                          quant_i,
  output neureka_ctrl_pkg::ctrl_state_t state_o,
  output logic                          state_change_o,
  output logic                          capture_o,
  output logic                          release_o,
  output logic                          loop_clear_o,
  output logic                          step_o,
  output logic                          sample_o
);

  neureka_ctrl_pkg::ctrl_state_t state_d, state_q;
  logic                          state_change_q;

  //////////////////////////////
  // Next state

  always_comb begin : next_state
    state_d = state_q;
    case (state_q)
      neureka_ctrl_pkg::ST_IDLE: begin
        if (start_i && !busy_i) state_d = neureka_ctrl_pkg::ST_LOAD;
      end
      neureka_ctrl_pkg::ST_LOAD: begin
        if (load_done_i) begin
          state_d = streamin_en_i ? neureka_ctrl_pkg::ST_STREAMIN
                                  : neureka_ctrl_pkg::ST_WEIGHTOFFS;
        end
      end
      neureka_ctrl_pkg::ST_STREAMIN: begin
        if (streamin_done_i) state_d = neureka_ctrl_pkg::ST_WEIGHTOFFS;
      end
      neureka_ctrl_pkg::ST_WEIGHTOFFS: begin
        if (accum_done_i) state_d = neureka_ctrl_pkg::ST_MATRIXVEC;
      end
      neureka_ctrl_pkg::ST_MATRIXVEC: begin
        if (accum_done_i) state_d = neureka_ctrl_pkg::ST_UPDATEIDX;
      end
      neureka_ctrl_pkg::ST_UPDATEIDX: begin
        if (step_done_i) begin
          if (inner_only_i && !last_i) begin
            state_d = neureka_ctrl_pkg::ST_LOAD;  // Same output tile, next input slice
          end else if (quant_i) begin
            state_d = neureka_ctrl_pkg::ST_NORMQUANT;
          end else begin
            state_d = neureka_ctrl_pkg::ST_STREAMOUT;
          end
        end
      end
      neureka_ctrl_pkg::ST_NORMQUANT: begin
        if (normquant_done_i) state_d = neureka_ctrl_pkg::ST_STREAMOUT;
      end
      neureka_ctrl_pkg::ST_STREAMOUT: begin
        if (streamout_done_i) begin
          state_d = last_i ? neureka_ctrl_pkg::ST_DONE
                           : neureka_ctrl_pkg::ST_STREAMOUT_DONE;
        end
      end
      neureka_ctrl_pkg::ST_STREAMOUT_DONE: begin
        if (fifo_empty_i) state_d = neureka_ctrl_pkg::ST_LOAD;  // Wait for the writes to drain
      end
      neureka_ctrl_pkg::ST_DONE: begin
        state_d = neureka_ctrl_pkg::ST_IDLE;
      end
      default: begin
        state_d = neureka_ctrl_pkg::ST_IDLE;
      end
    endcase
    if (clear_i) begin
      state_d = neureka_ctrl_pkg::ST_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= neureka_ctrl_pkg::ST_IDLE;
      state_change_q <= 1'b0;
    end else begin
      state_q        <= state_d;
      state_change_q <= (state_d != state_q);
    end
  end

  //////////////////////////////
  // Outputs

  assign state_o        = state_q;
  assign state_change_o = state_change_q;

  assign capture_o    = (state_q == neureka_ctrl_pkg::ST_IDLE) &&
                        (state_d == neureka_ctrl_pkg::ST_LOAD);
  assign release_o    = (state_q == neureka_ctrl_pkg::ST_DONE);
  assign loop_clear_o = clear_i || (state_q == neureka_ctrl_pkg::ST_IDLE);  // Counters rest at 0
  assign step_o       = (state_q == neureka_ctrl_pkg::ST_UPDATEIDX) && state_change_q;
  assign sample_o     = (state_d == neureka_ctrl_pkg::ST_LOAD) &&
                        (state_q != neureka_ctrl_pkg::ST_LOAD);

endmodule

`default_nettype wire

//--- verilog/neureka_ctrl_pkg.sv
//////////////////////////////
// Convolution tile sequencer definitions
// Counter widths, loop level positions, vector types
// and the controller state encoding
//////////////////////////////

`default_nettype none

package neureka_ctrl_pkg;

  localparam int unsigned NUM_LOOPS = 4;
  localparam int unsigned CNT_W     = 8;
  localparam int unsigned IDX_W     = NUM_LOOPS * CNT_W;

  //////////////////////////////
  // Loop levels, innermost first

  // Dense ordering
  localparam int unsigned LOOP_KI = 0;
  localparam int unsigned LOOP_WO = 1;
  localparam int unsigned LOOP_HO = 2;
  localparam int unsigned LOOP_KO = 3;

  // Depthwise ordering, the top level is a single pass
  localparam int unsigned DW_LOOP_WO  = 0;
  localparam int unsigned DW_LOOP_HO  = 1;
  localparam int unsigned DW_LOOP_KO  = 2;
  localparam int unsigned DW_LOOP_PAD = 3;

  //////////////////////////////
  // Types

  typedef logic [CNT_W-1:0]     cnt_t;
  typedef cnt_t [NUM_LOOPS-1:0] cnt_vec_t;   // One count per level
  typedef logic [NUM_LOOPS-1:0] loop_vec_t;  // One flag per level
  typedef logic [IDX_W-1:0]     tile_index_t; // {k_out, i, j, k_in}

  typedef enum logic {
    MODE_DENSE = 1'b0,
    MODE_DW    = 1'b1
  } filter_mode_t;

  typedef enum logic [3:0] {
    ST_IDLE           = 4'd0,
    ST_LOAD           = 4'd1,
    ST_STREAMIN       = 4'd2,
    ST_WEIGHTOFFS     = 4'd3,
    ST_MATRIXVEC      = 4'd4,
    ST_UPDATEIDX      = 4'd5,
    ST_NORMQUANT      = 4'd6,
    ST_STREAMOUT      = 4'd7,
    ST_STREAMOUT_DONE = 4'd8,
    ST_DONE           = 4'd9
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- verilog/neureka_ctrl_top.sv
//////////////////////////////
// Convolution sequencing controller
// Configuration, loop nest, tile index and FSM
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module neureka_ctrl_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           clear_i,
  input  logic                           start_i,
  input  neureka_ctrl_pkg::filter_mode_t mode_i,
  input  neureka_ctrl_pkg::cnt_t         nb_ki_i,
  input  neureka_ctrl_pkg::cnt_t         nb_wo_i,
  input  neureka_ctrl_pkg::cnt_t         nb_ho_i,
  input  neureka_ctrl_pkg::cnt_t         nb_ko_i,
  input  logic                           streamin_i,
  input  logic                           quant_i,
  input  logic                           load_done_i,
  input  logic                           streamin_done_i,
  input  logic                           accum_done_i,
  input  logic                           normquant_done_i,
  input  logic                           streamout_done_i,
  input  logic                           fifo_empty_i,
  output neureka_ctrl_pkg::ctrl_state_t  state_o,
  output logic                           state_change_o,
  output neureka_ctrl_pkg::tile_index_t  index_o
);

  neureka_ctrl_pkg::filter_mode_t mode;
  neureka_ctrl_pkg::cnt_t         nb_ki, nb_wo, nb_ho, nb_ko;
  neureka_ctrl_pkg::cnt_vec_t     cnt;
  neureka_ctrl_pkg::loop_vec_t    update;
  logic                           streamin_cfg, quant, busy;
  logic                           capture, release_cfg, loop_clear, step, sample;
  logic                           step_done, inner_only, last, streamin_en;

  neureka_cfg_reg i_cfg_reg (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .capture_i  (capture),
    .release_i  (release_cfg),
    .mode_i     (mode_i),
    .nb_ki_i    (nb_ki_i),
    .nb_wo_i    (nb_wo_i),
    .nb_ho_i    (nb_ho_i),
    .nb_ko_i    (nb_ko_i),
    .streamin_i (streamin_i),
    .quant_i    (quant_i),
    .mode_o     (mode),
    .nb_ki_o    (nb_ki),
    .nb_wo_o    (nb_wo),
    .nb_ho_o    (nb_ho),
    .nb_ko_o    (nb_ko),
    .streamin_o (streamin_cfg),
    .quant_o    (quant),
    .busy_o     (busy)
  );

  neureka_loop_nest i_loop_nest (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (loop_clear),
    .step_i       (step),
    .mode_i       (mode),
    .nb_ki_i      (nb_ki),
    .nb_wo_i      (nb_wo),
    .nb_ho_i      (nb_ho),
    .nb_ko_i      (nb_ko),
    .cnt_o        (cnt),
    .step_done_o  (step_done),
    .update_o     (update),
    .inner_only_o (inner_only),
    .last_o       (last)
  );

  neureka_index_reg i_index_reg (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .sample_i       (sample),
    .mode_i         (mode),
    .cnt_i          (cnt),
    .update_i       (update),
    .streamin_cfg_i (streamin_cfg),
    .index_o        (index_o),
    .streamin_en_o  (streamin_en)
  );

  neureka_ctrl_fsm i_ctrl_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .clear_i          (clear_i),
    .start_i          (start_i),
    .busy_i           (busy),
    .load_done_i      (load_done_i),
    .streamin_done_i  (streamin_done_i),
    .accum_done_i     (accum_done_i),
    .normquant_done_i (normquant_done_i),
    .streamout_done_i (streamout_done_i),
    .fifo_empty_i     (fifo_empty_i),
    .step_done_i      (step_done),
    .inner_only_i     (inner_only),
    .last_i           (last),
    .streamin_en_i    (streamin_en),
    .quant_i          (quant),
    .state_o          (state_o),
    .state_change_o   (state_change_o),
    .capture_o        (capture),
    .release_o        (release_cfg),
    .loop_clear_o     (loop_clear),
    .step_o           (step),
    .sample_o         (sample)
  );

endmodule

`default_nettype wire

//--- verilog/neureka_index_reg.sv
//////////////////////////////
// Tile index register
// Remaps the loop counts to tile fields, samples them
// at load and decides whether stream-in is needed
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module neureka_index_reg (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           clear_i,
  input  logic                           sample_i,
  input  neureka_ctrl_pkg::filter_mode_t mode_i,
  input  neureka_ctrl_pkg::cnt_vec_t     cnt_i,
  input  neureka_ctrl_pkg::loop_vec_t    update_i,
  input  logic                           streamin_cfg_i,
  output neureka_ctrl_pkg::tile_index_t  index_o,
  output logic                           streamin_en_o
);

  neureka_ctrl_pkg::tile_index_t index_map, index_q;
  logic                          outer_upd;

  always_comb begin : remap
    if (mode_i == neureka_ctrl_pkg::MODE_DW) begin
      // Input and output channels advance together
      index_map = {cnt_i[neureka_ctrl_pkg::DW_LOOP_KO], cnt_i[neureka_ctrl_pkg::DW_LOOP_HO],
                   cnt_i[neureka_ctrl_pkg::DW_LOOP_WO], cnt_i[neureka_ctrl_pkg::DW_LOOP_KO]};
      outer_upd = update_i[neureka_ctrl_pkg::DW_LOOP_KO] |
                  update_i[neureka_ctrl_pkg::DW_LOOP_HO] |
                  update_i[neureka_ctrl_pkg::DW_LOOP_WO];
    end else begin
      index_map = {cnt_i[neureka_ctrl_pkg::LOOP_KO], cnt_i[neureka_ctrl_pkg::LOOP_HO],
                   cnt_i[neureka_ctrl_pkg::LOOP_WO], cnt_i[neureka_ctrl_pkg::LOOP_KI]};
      outer_upd = update_i[neureka_ctrl_pkg::LOOP_KO] |
                  update_i[neureka_ctrl_pkg::LOOP_HO] |
                  update_i[neureka_ctrl_pkg::LOOP_WO];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      index_q <= '0;
    end else if (clear_i) begin
      index_q <= '0;
    end else if (sample_i) begin
      index_q <= index_map;
    end
  end

  assign index_o = index_q;

  // A new output tile, or the very first one, needs its partial sums
  assign streamin_en_o = streamin_cfg_i & (outer_upd | (index_q == '0));

endmodule

`default_nettype wire

//--- verilog/neureka_loop_nest.sv
//////////////////////////////
// Subtile loop nest
// Four odometer counters with dense or depthwise ranges
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module neureka_loop_nest (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           clear_i,
  input  logic                           step_i,
  input  neureka_ctrl_pkg::filter_mode_t mode_i,
  input  neureka_ctrl_pkg::cnt_t         nb_ki_i,
  input  neureka_ctrl_pkg::cnt_t         nb_wo_i,
  input  neureka_ctrl_pkg::cnt_t         nb_ho_i,
  input  neureka_ctrl_pkg::cnt_t         nb_ko_i,
  output neureka_ctrl_pkg::cnt_vec_t     cnt_o,
  output logic                           step_done_o,
  output neureka_ctrl_pkg::loop_vec_t    update_o,
  output logic                           inner_only_o,
  output logic                           last_o
);

  neureka_ctrl_pkg::cnt_vec_t  rng;
  neureka_ctrl_pkg::cnt_vec_t  cnt_d, cnt_q;
  neureka_ctrl_pkg::loop_vec_t upd_d, update_q;
  logic                        last_d, last_q;
  logic                        inner_only_d, inner_only_q;
  logic                        step_done_q;

  always_comb begin : range_sel
    if (mode_i == neureka_ctrl_pkg::MODE_DW) begin
      rng[neureka_ctrl_pkg::DW_LOOP_WO]  = nb_wo_i;
      rng[neureka_ctrl_pkg::DW_LOOP_HO]  = nb_ho_i;
      rng[neureka_ctrl_pkg::DW_LOOP_KO]  = nb_ko_i;
      rng[neureka_ctrl_pkg::DW_LOOP_PAD] = neureka_ctrl_pkg::cnt_t'(1);
    end else begin
      rng[neureka_ctrl_pkg::LOOP_KI] = nb_ki_i;
      rng[neureka_ctrl_pkg::LOOP_WO] = nb_wo_i;
      rng[neureka_ctrl_pkg::LOOP_HO] = nb_ho_i;
      rng[neureka_ctrl_pkg::LOOP_KO] = nb_ko_i;
    end
  end

  // Level 0 always moves, a wrapping level passes the carry outward
  always_comb begin : odometer
    logic                               carry;
    logic [neureka_ctrl_pkg::CNT_W:0]   nxt;
    carry = 1'b1;
    cnt_d = cnt_q;
    for (int l = 0; l < neureka_ctrl_pkg::NUM_LOOPS; l++) begin
      nxt = {1'b0, cnt_q[l]} + 1'b1;
      if (carry) begin
        if (nxt >= {1'b0, rng[l]}) begin
          cnt_d[l] = '0;
        end else begin
          cnt_d[l] = nxt[neureka_ctrl_pkg::CNT_W-1:0];
          carry    = 1'b0;
        end
      end
    end
    last_d = carry;  // Every level wrapped, nothing is left
    if (last_d) begin
      cnt_d = cnt_q;
    end
    for (int l = 0; l < neureka_ctrl_pkg::NUM_LOOPS; l++) begin
      upd_d[l] = (cnt_d[l] != cnt_q[l]);
    end
    inner_only_d = (upd_d == neureka_ctrl_pkg::loop_vec_t'(1)) &&
                   (mode_i == neureka_ctrl_pkg::MODE_DENSE);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q        <= '0;
      update_q     <= '0;
      last_q       <= 1'b0;
      inner_only_q <= 1'b0;
      step_done_q  <= 1'b0;
    end else if (clear_i) begin
      cnt_q        <= '0;
      update_q     <= '0;
      last_q       <= 1'b0;
      inner_only_q <= 1'b0;
      step_done_q  <= 1'b0;
    end else begin
      step_done_q <= step_i;
      if (step_i) begin
        cnt_q        <= cnt_d;
        update_q     <= upd_d;
        last_q       <= last_d;
        inner_only_q <= inner_only_d;
      end
    end
  end

  assign cnt_o        = cnt_q;
  assign step_done_o  = step_done_q;
  assign update_o     = update_q;     // Results stay valid until the next step
  assign inner_only_o = inner_only_q;
  assign last_o       = last_q;

endmodule

`default_nettype wire
